//--- hdl/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    ////////////////////////////////////////////////
    // widths that carry a meaning
    ////////////////////////////////////////////////
    typedef logic [15:0] addr_t;                // processor bus address
    typedef logic [15:0] word_t;                // processor bus data
    typedef logic [7:0]  byte_t;                // spart data byte
    typedef logic [9:0]  led_t;                 // board leds
    typedef logic [9:0]  sw_t;                  // board switches
    typedef logic [1:0]  ioaddr_t;              // spart register index
    typedef logic [3:0]  qcount_t;              // queue occupancy 0..8

    // address map
    localparam addr_t LED_ADDR        = 16'hC000;
    localparam addr_t SPART_DATA_ADDR = 16'hC004;   // tx push / rx pop
    localparam addr_t SPART_STAT_ADDR = 16'hC005;   // queue status
    localparam addr_t SPART_DIVL_ADDR = 16'hC006;   // divisor low byte
    localparam addr_t SPART_DIVH_ADDR = 16'hC007;   // divisor high byte

    // spart register indices
    localparam ioaddr_t IO_DATA   = 2'd0;
    localparam ioaddr_t IO_STATUS = 2'd1;
    localparam ioaddr_t IO_DIVL   = 2'd2;
    localparam ioaddr_t IO_DIVH   = 2'd3;

    localparam int          QUEUE_DEPTH = 8;        // both spart queues
    localparam logic [15:0] DIV_RESET   = 16'h00A2; // baud divisor out of reset

    // processor side bus request
    typedef struct packed {
        addr_t addr;                            // byte address
        word_t wdata;                           // write data
        logic  we;                              // write strobe
        logic  re;                              // read strobe
    } io_req_t;

    // decoded access into the spart
    typedef struct packed {
        logic    cs;                            // spart selected this cycle
        logic    wr;                            // 1 write, 0 read
        ioaddr_t ioaddr;                        // register index
        byte_t   wdata;                         // low byte of bus data
    } spart_req_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

//--- hdl/rst_synch.sv
`timescale 1ns/100ps
`default_nettype none

module rst_synch (
    input  logic clk,
    input  logic rst_n_raw,                     // from the board button
    output logic rst_n                          // synchronized release
);

    logic ff1;                                  // first stage, may go metastable

    always_ff @(posedge clk or negedge rst_n_raw) begin
        if (!rst_n_raw) begin
            ff1   <= 1'b0;                      // assert right away
            rst_n <= 1'b0;
        end else begin
            ff1   <= 1'b1;                      // shift a one through
            rst_n <= ff1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo import mmio_pkg::*; #(
    parameter int DEPTH = QUEUE_DEPTH           // power of two, 8 max
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push,
    input  byte_t   wdata,
    input  logic    pop,
    output byte_t   rdata,                      // head of queue, valid when !empty
    output logic    full,
    output logic    empty,
    output qcount_t count
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    byte_t          mem [DEPTH];                // storage
    logic [PW-1:0]  wr_ptr, rd_ptr;
    logic           do_push, do_pop;

    assign full    = (count == qcount_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;              // push on full is dropped
    assign do_pop  = pop & ~empty;              // pop on empty does nothing
    assign rdata   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count;        // none, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/baud_gen.sv
`timescale 1ns/100ps
`default_nettype none

module baud_gen import mmio_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  div_wr,                       // load one divisor half
    input  logic  div_sel,                      // 1 high byte, 0 low byte
    input  byte_t div_byte,
    output logic  tick                          // 16x baud strobe
);

    logic [15:0] div;                           // programmed divisor
    logic [15:0] div_next;                      // divisor after this write
    logic [15:0] cnt;                           // down counter

    // merge the new half with the half that stays
    always_comb begin
        if (div_sel)
            div_next = {div_byte, div[7:0]};
        else
            div_next = {div[15:8], div_byte};
    end

    assign tick = (cnt == '0);                  // once every div+1 clocks

    ////////////////////////////////////////////////
    // divisor register and tick counter
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div <= DIV_RESET;
            cnt <= DIV_RESET;
        end else if (div_wr) begin
            div <= div_next;
            cnt <= div_next;                    // restart on the new rate
        end else if (tick) begin
            cnt <= div;                         // reload
        end else begin
            cnt <= cnt - 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module spart_tx import mmio_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tick,                         // 16x baud strobe
    input  logic  q_empty,                      // tx queue empty
    input  byte_t q_data,                       // tx queue head
    output logic  q_pop,                        // take the head byte
    output logic  tx                            // serial out
);

    tx_state_t   state;
    logic [3:0]  tick_cnt;                      // ticks within one bit
    logic [2:0]  bit_idx;                       // data bit being sent
    byte_t       shreg;                         // shifts out lsb first
    logic        bit_done;                      // last tick of a bit

    assign bit_done = tick & (tick_cnt == 4'hF);
    assign q_pop    = (state == TX_IDLE) & ~q_empty;   // one cycle, only from idle

    // line level follows the state
    always_comb begin
        case (state)
            TX_START: tx = 1'b0;
            TX_DATA:  tx = shreg[0];
            default:  tx = 1'b1;                // idle and stop are high
        endcase
    end

    always_ff @(posedge clk) begin
        if (q_pop)
            shreg <= q_data;                    // grab byte as it is popped
        else if ((state == TX_DATA) && bit_done)
            shreg <= shreg >> 1;
    end

    ////////////////////////////////////////////////
    // frame sequencer
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            if (state == TX_IDLE)
                tick_cnt <= '0;
            else if (tick)
                tick_cnt <= tick_cnt + 4'd1;    // wraps at 16
            case (state)
                TX_IDLE:  if (q_pop) state <= TX_START;
                TX_START: if (bit_done) begin
                    bit_idx <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA:  if (bit_done) begin
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7)
                        state <= TX_STOP;       // eighth bit sent
                end
                TX_STOP:  if (bit_done) state <= TX_IDLE;
                default:  state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/spart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module spart_rx import mmio_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tick,                         // 16x baud strobe
    input  logic  rx,                           // async serial in
    output logic  push,                         // one cycle, byte is good
    output byte_t byte_out
);

    rx_state_t   state;
    logic        rx_meta, rx_sync, rx_prev;     // two sync flops plus edge history
    logic [3:0]  tick_cnt;
    logic [2:0]  bit_idx;
    byte_t       shreg;                         // assembles lsb first
    logic        half_done;                     // middle of start bit
    logic        bit_done;                      // middle of data or stop bit

    assign half_done = tick & (tick_cnt == 4'd7);
    assign bit_done  = tick & (tick_cnt == 4'hF);
    assign byte_out  = shreg;

    ////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                    // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && bit_done)
            shreg <= {rx_sync, shreg[7:1]};     // new bit enters at the top
    end

    ////////////////////////////////////////////////
    // frame tracking
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            if (state == RX_IDLE)
                tick_cnt <= '0;
            else if (half_done && state == RX_START)
                tick_cnt <= '0;                 // realign to bit centres
            else if (tick)
                tick_cnt <= tick_cnt + 4'd1;
            case (state)
                RX_IDLE:  if (rx_prev & ~rx_sync) state <= RX_START;   // falling edge
                RX_START: if (half_done) begin
                    bit_idx <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch if high
                end
                RX_DATA:  if (bit_done) begin
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7)
                        state <= RX_STOP;
                end
                RX_STOP:  if (bit_done) begin
                    push  <= rx_sync;           // low stop bit drops the byte
                    state <= RX_IDLE;
                end
                default:  state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/spart.sv
`timescale 1ns/100ps
`default_nettype none

module spart import mmio_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  spart_req_t req,                     // decoded access from the top
    output byte_t      rd_data,                 // combinational read data
    output logic       tx,
    input  logic       rx
);

    logic    tx_push, tx_pop, tx_full, tx_empty;
    logic    rx_push, rx_pop, rx_empty;
    byte_t   tx_head, rx_head, rx_byte;
    qcount_t tx_count, rx_count, tx_free;
    logic    div_wr, tick;
    byte_t   status;

    ////////////////////////////////////////////////
    // register access
    ////////////////////////////////////////////////
    assign tx_push = req.cs & req.wr & (req.ioaddr == IO_DATA) & ~tx_full;  // full drops
    assign rx_pop  = req.cs & ~req.wr & (req.ioaddr == IO_DATA);            // pop on read
    assign div_wr  = req.cs & req.wr & ((req.ioaddr == IO_DIVL) | (req.ioaddr == IO_DIVH));

    assign tx_free = qcount_t'(QUEUE_DEPTH) - tx_count;
    assign status  = {tx_free, rx_count};       // free slots high, rx count low

    always_comb begin
        case (req.ioaddr)
            IO_DATA:   rd_data = rx_empty ? 8'h00 : rx_head;
            IO_STATUS: rd_data = status;
            default:   rd_data = 8'h00;         // divisor is write only
        endcase
    end

    byte_fifo #(.DEPTH(QUEUE_DEPTH)) u_txq (
        .clk(clk), .rst_n(rst_n),
        .push(tx_push), .wdata(req.wdata),
        .pop(tx_pop), .rdata(tx_head),
        .full(tx_full), .empty(tx_empty), .count(tx_count)
    );

    byte_fifo #(.DEPTH(QUEUE_DEPTH)) u_rxq (
        .clk(clk), .rst_n(rst_n),
        .push(rx_push), .wdata(rx_byte),        // lost when full
        .pop(rx_pop), .rdata(rx_head),
        .full(), .empty(rx_empty), .count(rx_count)
    );

    baud_gen u_baud (
        .clk(clk), .rst_n(rst_n),
        .div_wr(div_wr),
        .div_sel(req.ioaddr == IO_DIVH),        // high half select
        .div_byte(req.wdata),
        .tick(tick)
    );

    spart_tx u_tx (
        .clk(clk), .rst_n(rst_n), .tick(tick),
        .q_empty(tx_empty), .q_data(tx_head), .q_pop(tx_pop),
        .tx(tx)
    );

    spart_rx u_rx (
        .clk(clk), .rst_n(rst_n), .tick(tick),
        .rx(rx),
        .push(rx_push), .byte_out(rx_byte)
    );

endmodule

`default_nettype wire

//--- hdl/mini_soc.sv
`timescale 1ns/100ps
`default_nettype none

module mini_soc import mmio_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_raw,                  // raw board reset
    input  io_req_t bus,                        // processor side request
    output word_t   rdata,                      // same cycle read data
    input  sw_t     sw,
    output led_t    led,
    output logic    tx,
    input  logic    rx
);

    logic       rst_n;                          // synchronized reset
    logic       is_led, is_data, is_stat, is_divl, is_divh;
    spart_req_t spart_req;
    byte_t      spart_rd;

    ////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////
    assign is_led  = (bus.addr == LED_ADDR);
    assign is_data = (bus.addr == SPART_DATA_ADDR);
    assign is_stat = (bus.addr == SPART_STAT_ADDR);
    assign is_divl = (bus.addr == SPART_DIVL_ADDR);
    assign is_divh = (bus.addr == SPART_DIVH_ADDR);

    // status is read only, divisor is write only
    assign spart_req.cs = (bus.re & (is_data | is_stat)) |
                          (bus.we & (is_data | is_divl | is_divh));
    assign spart_req.wr = bus.we;
    assign spart_req.wdata = bus.wdata[7:0];

    always_comb begin
        if (is_data)
            spart_req.ioaddr = IO_DATA;
        else if (is_divl)
            spart_req.ioaddr = IO_DIVL;
        else if (is_divh)
            spart_req.ioaddr = IO_DIVH;
        else
            spart_req.ioaddr = IO_STATUS;       // 0xC005 and anything else
    end

    ////////////////////////////////////////////////
    // led output and read mux
    ////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            led <= '0;
        else if (is_led & bus.we)
            led <= bus.wdata[9:0];              // low ten bits drive the leds
    end

    // spart byte for its two readable addresses, switches elsewhere
    assign rdata = (is_data | is_stat) ? {8'h00, spart_rd} : {6'h00, sw};

    rst_synch u_rst (
        .clk(clk),
        .rst_n_raw(rst_n_raw),
        .rst_n(rst_n)
    );

    spart u_spart (
        .clk(clk),
        .rst_n(rst_n),
        .req(spart_req),
        .rd_data(spart_rd),
        .tx(tx),
        .rx(rx)
    );

endmodule

`default_nettype wire

//--- dv/mini_soc_props.sv
`timescale 1ns/100ps
`default_nettype none

module mini_soc_props import mmio_pkg::*; (
    input logic      clk,
    input logic      rst_n,                     // synchronized reset
    input logic      tx,
    input tx_state_t tx_state,
    input qcount_t   tx_count,
    input qcount_t   rx_count,
    input io_req_t   bus,
    input led_t      led
);

    int unsigned fail_cnt = 0;                  // failed assertions so far

    // line stays high while the transmitter has nothing to send
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state == TX_IDLE && tx_count == '0) |=> tx)
        else begin
            fail_cnt++;
            $error("tx went low while the transmitter was idle with nothing queued");
        end

    txq_bound: assert property (@(posedge clk) disable iff (!rst_n)
        tx_count <= qcount_t'(QUEUE_DEPTH))
        else begin
            fail_cnt++;
            $error("tx queue count above depth");
        end

    rxq_bound: assert property (@(posedge clk) disable iff (!rst_n)
        rx_count <= qcount_t'(QUEUE_DEPTH))
        else begin
            fail_cnt++;
            $error("rx queue count above depth");
        end

    // led only moves after a write to its address
    led_write_only: assert property (@(posedge clk) disable iff (!rst_n)
        (led != $past(led)) |-> $past(bus.we && (bus.addr == LED_ADDR)))
        else begin
            fail_cnt++;
            $error("led changed without a write to the led address");
        end

endmodule

bind mini_soc mini_soc_props props_i (
    .clk(clk), .rst_n(rst_n), .tx(tx),
    .tx_state(u_spart.u_tx.state),
    .tx_count(u_spart.tx_count), .rx_count(u_spart.rx_count),
    .bus(bus), .led(led)
);

`default_nettype wire

//--- dv/mini_soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mini_soc_tb import mmio_pkg::*; ();

    localparam int FRAME_CYCLES = 10 * 16 * 2;  // one 8N1 frame at divisor 1
    localparam int MAX_CYCLES   = 30000;        // 18 frames of FRAME_CYCLES plus margin
    localparam int LOOP_BYTES   = 6;

    logic    clk;
    logic    rst_n_raw;
    io_req_t bus;
    word_t   rdata;
    sw_t     sw;
    led_t    led;
    logic    serial;                            // tx looped straight back to rx
    int      cycles = 0;
    int      seed;

    led_t    led_m;                             // model of the led register
    byte_t   exp_q[$];                          // bytes sent and not yet read back
    string   name_q[$];                         // pending compares for the checker
    word_t   want_q[$];
    word_t   got_q[$];

    mini_soc mini_soc_i (
        .clk(clk), .rst_n_raw(rst_n_raw),
        .bus(bus), .rdata(rdata),
        .sw(sw), .led(led),
        .tx(serial), .rx(serial)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                       // 10 ns period

    ////////////////////////////////////////////////
    // reference model and checking
    ////////////////////////////////////////////////
    function automatic word_t ref_read(addr_t addr, sw_t sw_m, byte_t q[$]);
        word_t r;
        if (addr == SPART_DATA_ADDR)
            r = (q.size() == 0) ? 16'h0000 : {8'h00, q[0]};    // empty reads 0
        else if (addr == SPART_STAT_ADDR)
            r = {8'h00, 4'(QUEUE_DEPTH), 4'(q.size())};     // line quiet and tx queue drained
        else
            r = {6'h00, sw_m};                  // every other address reads switches
        return r;
    endfunction

    task automatic check_eq(string name, word_t want, word_t got);
        if (want !== got) begin
            $display("CHECK FAILED %s: expected 0x%04h, actual 0x%04h", name, want, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic expect_eq(string name, word_t want, word_t got);
        name_q.push_back(name);
        want_q.push_back(want);
        got_q.push_back(got);
    endtask

    // compare process drains whatever the stimulus queued up
    always @(negedge clk) begin
        while (got_q.size() > 0)
            check_eq(name_q.pop_front(), want_q.pop_front(), got_q.pop_front());
        if (mini_soc_i.props_i.fail_cnt != 0) begin
            $display("a bound assertion on the DUT failed");
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////
    // bus tasks are entered 1 ns after a rising edge
    ////////////////////////////////////////////////
    task automatic bus_write(addr_t addr, word_t data);
        bus.addr  = addr;
        bus.wdata = data;
        bus.re    = 1'b0;
        bus.we    = 1'b1;
        @(posedge clk);
        #1;
        bus.we = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, input string name, input bit chk,
                            output word_t data);
        bus.addr = addr;
        bus.we   = 1'b0;
        bus.re   = 1'b1;
        @(negedge clk);                         // rdata settled mid cycle
        data = rdata;
        if (chk)
            expect_eq(name, ref_read(addr, sw, exp_q), data);
        if (addr == SPART_DATA_ADDR && exp_q.size() > 0)
            void'(exp_q.pop_front());           // the read pops the rx queue
        @(posedge clk);
        #1;
        bus.re = 1'b0;
    endtask

    task automatic wait_rx_byte();
        word_t st;
        st = '0;
        while (st[3:0] == 4'd0)
            bus_read(SPART_STAT_ADDR, "status poll", 1'b0, st);
    endtask

    function automatic addr_t random_plain_addr();
        addr_t a;
        a = addr_t'($urandom());
        while (a == LED_ADDR || (a >= SPART_DATA_ADDR && a <= SPART_DIVH_ADDR))
            a = addr_t'($urandom());            // keep clear of led and spart
        return a;
    endfunction

    ////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////
    initial begin
        word_t rd;
        word_t w;
        byte_t b;
        int    sent;
        int    got;
        seed = 68;
        void'($urandom(seed));
        bus       = '0;
        sw        = '0;
        led_m     = '0;
        rst_n_raw = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n_raw = 1'b1;
        repeat (3) @(posedge clk);              // let the synchronizer release
        #1;

        // state out of reset
        expect_eq("reset led", 16'h0000, {6'h00, led});
        expect_eq("reset tx", 16'h0001, {15'h0000, serial});
        bus_read(SPART_STAT_ADDR, "reset status", 1'b1, rd);
        bus_read(SPART_DATA_ADDR, "empty data read", 1'b1, rd);

        // led register
        repeat (5) begin
            w     = word_t'($urandom());
            led_m = w[9:0];
            bus_write(LED_ADDR, w);
            expect_eq("led write", {6'h00, led_m}, {6'h00, led});
        end
        repeat (5) begin
            bus_write(random_plain_addr(), word_t'($urandom()));
            expect_eq("led hold", {6'h00, led_m}, {6'h00, led});
        end

        // switch read path
        repeat (5) begin
            sw = sw_t'($urandom());
            bus_read(random_plain_addr(), "switch read", 1'b1, rd);
        end
        sw = sw_t'($urandom());
        bus_read(SPART_DIVL_ADDR, "switch read divl", 1'b1, rd);

        // single byte loopback at divisor 1
        bus_write(SPART_DIVL_ADDR, 16'h0001);
        bus_write(SPART_DIVH_ADDR, 16'h0000);
        repeat (LOOP_BYTES) begin
            b = byte_t'($urandom());
            bus_write(SPART_DATA_ADDR, {8'h00, b});
            exp_q.push_back(b);
            wait_rx_byte();
            bus_read(SPART_DATA_ADDR, "loopback byte", 1'b1, rd);
        end

        // burst until the tx queue is full and then one write that is dropped
        sent = 0;
        bus_read(SPART_STAT_ADDR, "status poll", 1'b0, rd);
        while (rd[7:4] != 4'd0) begin
            b = byte_t'($urandom());
            bus_write(SPART_DATA_ADDR, {8'h00, b});
            exp_q.push_back(b);
            sent++;
            bus_read(SPART_STAT_ADDR, "status poll", 1'b0, rd);
        end
        bus_write(SPART_DATA_ADDR, 16'h00A5);   // no free slot
        // one byte sits in the shifter so the rx queue is drained as bytes land
        got = 0;
        while (got < sent) begin
            wait_rx_byte();
            bus_read(SPART_DATA_ADDR, "burst byte", 1'b1, rd);
            got++;
        end
        repeat (2 * FRAME_CYCLES) @(posedge clk);   // an accepted extra byte would show up here
        #1;
        bus_read(SPART_STAT_ADDR, "final status", 1'b1, rd);

        while (got_q.size() > 0)
            @(posedge clk);
        @(negedge clk);
        if (mini_soc_i.props_i.fail_cnt != 0) begin
            $display("a bound assertion on the DUT failed");
            $display(">>> FAIL");
            $fatal(1);
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/mmio_pkg.sv
hdl/rst_synch.sv
hdl/byte_fifo.sv
hdl/baud_gen.sv
hdl/spart_tx.sv
hdl/spart_rx.sv
hdl/spart.sv
hdl/mini_soc.sv
dv/mini_soc_props.sv
dv/mini_soc_tb.sv

//--- Bender.yml
package:
  name: mini_soc

sources:
  - hdl/mmio_pkg.sv
  - hdl/rst_synch.sv
  - hdl/byte_fifo.sv
  - hdl/baud_gen.sv
  - hdl/spart_tx.sv
  - hdl/spart_rx.sv
  - hdl/spart.sv
  - hdl/mini_soc.sv
  - target: test
    files:
      - dv/mini_soc_props.sv
      - dv/mini_soc_tb.sv
